// ==== src/rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data path width
`define RV_XLEN 32

`define RV_DMEM_WORDS 256
`define RV_RESET_PC 32'h0000_0000

// mcause codes
`define RV_CAUSE_ECALL 32'd11
`define RV_CAUSE_BREAK 32'd3

`endif

// ==== src/rv_isa_pkg.sv ====
`include "rv_params.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [2:0] funct3_t;

    typedef enum logic [6:0] {
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_system = 7'b1110011
    } opcode_e;

    localparam funct3_t f3_add = 3'b000; // add/sub, addi
    localparam funct3_t f3_sll = 3'b001;
    localparam funct3_t f3_slt = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor = 3'b100;
    localparam funct3_t f3_sr = 3'b101; // srl/sra by bit 30
    localparam funct3_t f3_or = 3'b110;
    localparam funct3_t f3_and = 3'b111;

    localparam funct3_t f3_byte = 3'b000; // load/store width
    localparam funct3_t f3_half = 3'b001;
    localparam funct3_t f3_word = 3'b010;
    localparam funct3_t f3_byte_u = 3'b100;
    localparam funct3_t f3_half_u = 3'b101;

    localparam funct3_t f3_priv = 3'b000; // ecall, ebreak, mret
    localparam funct3_t f3_csrrw = 3'b001;
    localparam funct3_t f3_csrrs = 3'b010;

    localparam csr_addr_t csr_mstatus = 12'h300;
    localparam csr_addr_t csr_mtvec = 12'h305;
    localparam csr_addr_t csr_mepc = 12'h341;
    localparam csr_addr_t csr_mcause = 12'h342;

endpackage

// ==== src/rv_exec_pkg.sv ====
package rv_exec_pkg;

    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_xor = 4'b0001,
        alu_or  = 4'b0010,
        alu_and = 4'b0011,
        alu_sll = 4'b0100,
        alu_srl = 4'b0101,
        alu_sra = 4'b0110,
        alu_set = 4'b1000 // less-than bit
    } alu_op_e;

    typedef enum logic [2:0] {
        csr_none,
        csr_write,
        csr_ecall,
        csr_ebreak,
        csr_mret
    } csr_ctl_e;

    typedef struct packed {
        rv_isa_pkg::word_t address;
        rv_isa_pkg::word_t wdata; // already shifted into its lanes
        logic [3:0]        wmask;
        logic              read;
        logic              write;
    } mem_req_t;

    typedef struct packed {
        logic                 valid;
        rv_isa_pkg::word_t    pc;
        rv_isa_pkg::reg_idx_t rd;
        logic                 rd_wen;
        rv_isa_pkg::word_t    rd_data;
    } retire_t;

endpackage

// ==== src/rv_alu.sv ====
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_alu (
    input  rv_isa_pkg::word_t    a,
    input  rv_isa_pkg::word_t    b,
    input  rv_exec_pkg::alu_op_e op,
    input  logic                 sub,
    input  logic                 sign,
    output rv_isa_pkg::word_t    result,
    output logic                 zero,
    output logic                 overflow,
    output logic                 carry
);

    rv_isa_pkg::word_t b_eff;
    rv_isa_pkg::word_t sum;
    logic less;

    assign b_eff = sub ? ~b : b; // two's complement with carry in
    assign {carry, sum} = {1'b0, a} + {1'b0, b_eff} + {{`RV_XLEN{1'b0}}, sub};
    assign overflow = (a[`RV_XLEN-1] == b_eff[`RV_XLEN-1]) &&
                      (sum[`RV_XLEN-1] != a[`RV_XLEN-1]);
    assign zero = (sum == '0);

    // carry out of a - b is set when there is no borrow
    assign less = sign ? (sum[`RV_XLEN-1] ^ overflow) : ~carry;

    always_comb begin
        case (op)
            rv_exec_pkg::alu_add: result = sum;
            rv_exec_pkg::alu_xor: result = a ^ b;
            rv_exec_pkg::alu_or:  result = a | b;
            rv_exec_pkg::alu_and: result = a & b;
            rv_exec_pkg::alu_sll: result = a << b[4:0];
            rv_exec_pkg::alu_srl: result = a >> b[4:0];
            rv_exec_pkg::alu_sra: result = $signed(a) >>> b[4:0];
            rv_exec_pkg::alu_set: result = {{(`RV_XLEN-1){1'b0}}, less};
            default:              result = '0;
        endcase
    end

endmodule

// ==== src/rv_data_mem.sv ====
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_data_mem (
    input  logic                  clk,
    input  rv_exec_pkg::mem_req_t req,
    input  logic                  accept,
    output rv_isa_pkg::word_t     rdata
);

    localparam int idx_w = $clog2(`RV_DMEM_WORDS);

    rv_isa_pkg::word_t mem [`RV_DMEM_WORDS];
    logic [idx_w-1:0] idx;

    assign idx = req.address[idx_w+1:2]; // word index, upper bits wrap

    always_ff @(posedge clk) begin
        if (req.write && accept) begin
            for (int i = 0; i < 4; i++) begin
                if (req.wmask[i]) begin
                    mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    assign rdata = req.read ? mem[idx] : '0;

endmodule

// ==== src/rv_csr_file.sv ====
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_csr_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  accept,
    input  rv_isa_pkg::csr_addr_t addr,
    input  rv_isa_pkg::word_t     wdata,
    input  logic                  wen,
    input  rv_exec_pkg::csr_ctl_e ctl,
    input  rv_isa_pkg::word_t     pc,
    output rv_isa_pkg::word_t     rdata,
    output rv_isa_pkg::word_t     trap_target
);

    rv_isa_pkg::word_t mstatus;
    rv_isa_pkg::word_t mtvec;
    rv_isa_pkg::word_t mepc;
    rv_isa_pkg::word_t mcause;

    always_comb begin
        case (addr)
            rv_isa_pkg::csr_mstatus: rdata = mstatus;
            rv_isa_pkg::csr_mtvec:   rdata = mtvec;
            rv_isa_pkg::csr_mepc:    rdata = mepc;
            rv_isa_pkg::csr_mcause:  rdata = mcause;
            default:                 rdata = '0;
        endcase
    end

    assign trap_target = (ctl == rv_exec_pkg::csr_mret) ? mepc : mtvec;

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus <= '0;
            mtvec <= '0;
            mepc <= '0;
            mcause <= '0;
        end else if (accept && wen) begin
            case (ctl)
                rv_exec_pkg::csr_write: begin
                    case (addr)
                        rv_isa_pkg::csr_mstatus: mstatus <= wdata;
                        rv_isa_pkg::csr_mtvec:   mtvec <= wdata;
                        rv_isa_pkg::csr_mepc:    mepc <= wdata;
                        rv_isa_pkg::csr_mcause:  mcause <= wdata;
                        default: ;
                    endcase
                end
                rv_exec_pkg::csr_ecall, rv_exec_pkg::csr_ebreak: begin
                    mepc <= pc;
                    mcause <= (ctl == rv_exec_pkg::csr_ecall) ? `RV_CAUSE_ECALL
                                                             : `RV_CAUSE_BREAK;
                    mstatus[7] <= mstatus[3]; // mpie <= mie
                    mstatus[3] <= 1'b0;
                    mstatus[12:11] <= 2'b11; // mpp, machine mode only
                end
                rv_exec_pkg::csr_mret: begin
                    mstatus[3] <= mstatus[7];
                    mstatus[7] <= 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== src/rv_exu.sv ====
`timescale 1ns/1ns

module rv_exu (
    input  logic                   clk,
    input  logic                   accept,
    input  rv_isa_pkg::opcode_e    opcode,
    input  rv_isa_pkg::funct3_t    funct3,
    input  rv_isa_pkg::word_t      src1,
    input  rv_isa_pkg::word_t      src2,
    input  rv_isa_pkg::word_t      imm,
    input  rv_isa_pkg::word_t      pc,
    input  rv_isa_pkg::word_t      csr_rdata,
    input  rv_isa_pkg::word_t      trap_target,
    output rv_isa_pkg::word_t      result,
    output logic                   rd_wen,
    output rv_isa_pkg::word_t      next_pc,
    output rv_isa_pkg::word_t      csr_wdata,
    output logic                   csr_wen,
    output rv_exec_pkg::csr_ctl_e  csr_ctl
);

    rv_isa_pkg::word_t alu_a;
    rv_isa_pkg::word_t alu_b;
    rv_isa_pkg::word_t alu_result;
    rv_exec_pkg::alu_op_e alu_op;
    logic alu_sub;
    logic alu_sign;
    logic alu_zero;
    rv_exec_pkg::mem_req_t mem_req;
    rv_isa_pkg::word_t mem_rdata;
    rv_isa_pkg::word_t load_shifted;
    rv_isa_pkg::word_t load_word;
    rv_isa_pkg::word_t pc_plus4;
    rv_isa_pkg::word_t pc_plus_imm;
    logic [1:0] byte_off;
    logic taken;

    assign pc_plus4 = pc + 32'd4;
    assign pc_plus_imm = pc + imm;
    assign byte_off = alu_result[1:0];

    always_comb begin
        alu_a = src1;
        alu_b = src2;
        alu_op = rv_exec_pkg::alu_add;
        alu_sub = 1'b0;
        alu_sign = 1'b0;
        result = alu_result;
        rd_wen = 1'b1;
        next_pc = pc_plus4;
        csr_wdata = alu_result;
        csr_wen = 1'b0;
        csr_ctl = rv_exec_pkg::csr_none;
        taken = 1'b0;
        case (opcode)
            rv_isa_pkg::op_imm, rv_isa_pkg::op_reg: begin
                if (opcode == rv_isa_pkg::op_imm) begin
                    alu_b = imm;
                end
                case (funct3)
                    rv_isa_pkg::f3_add: begin
                        alu_sub = (opcode == rv_isa_pkg::op_reg) && imm[10]; // sub
                    end
                    rv_isa_pkg::f3_sll: alu_op = rv_exec_pkg::alu_sll;
                    rv_isa_pkg::f3_slt: begin
                        alu_op = rv_exec_pkg::alu_set;
                        alu_sub = 1'b1;
                        alu_sign = 1'b1;
                    end
                    rv_isa_pkg::f3_sltu: begin
                        alu_op = rv_exec_pkg::alu_set;
                        alu_sub = 1'b1;
                    end
                    rv_isa_pkg::f3_xor: alu_op = rv_exec_pkg::alu_xor;
                    rv_isa_pkg::f3_sr: begin
                        alu_op = imm[10] ? rv_exec_pkg::alu_sra : rv_exec_pkg::alu_srl;
                    end
                    rv_isa_pkg::f3_or:  alu_op = rv_exec_pkg::alu_or;
                    rv_isa_pkg::f3_and: alu_op = rv_exec_pkg::alu_and;
                    default: ;
                endcase
            end
            rv_isa_pkg::op_lui: begin
                alu_a = '0;
                alu_b = imm;
            end
            rv_isa_pkg::op_auipc: begin
                alu_a = pc;
                alu_b = imm;
            end
            rv_isa_pkg::op_jal: begin
                alu_a = pc; // link pc+4
                alu_b = 32'd4;
                next_pc = pc_plus_imm;
            end
            rv_isa_pkg::op_jalr: begin
                alu_a = pc;
                alu_b = 32'd4;
                next_pc = (src1 + imm) & ~32'd1;
            end
            rv_isa_pkg::op_load: begin
                alu_b = imm;
                result = load_word;
            end
            rv_isa_pkg::op_store: begin
                alu_b = imm;
                rd_wen = 1'b0;
            end
            rv_isa_pkg::op_branch: begin
                alu_op = rv_exec_pkg::alu_set;
                alu_sub = 1'b1;
                alu_sign = ~funct3[1]; // bltu/bgeu unsigned
                rd_wen = 1'b0;
                // bit 2 picks lt over eq, bit 0 inverts
                taken = (funct3[2] ? alu_result[0] : alu_zero) ^ funct3[0];
                if (taken) begin
                    next_pc = pc_plus_imm;
                end
            end
            rv_isa_pkg::op_system: begin
                result = csr_rdata;
                case (funct3)
                    rv_isa_pkg::f3_priv: begin
                        rd_wen = 1'b0;
                        csr_wen = 1'b1;
                        next_pc = trap_target;
                        if (imm[1]) begin
                            csr_ctl = rv_exec_pkg::csr_mret;
                        end else if (imm[0]) begin
                            csr_ctl = rv_exec_pkg::csr_ebreak;
                        end else begin
                            csr_ctl = rv_exec_pkg::csr_ecall;
                        end
                    end
                    rv_isa_pkg::f3_csrrw: begin
                        alu_b = '0;
                        csr_wen = 1'b1;
                        csr_ctl = rv_exec_pkg::csr_write;
                    end
                    rv_isa_pkg::f3_csrrs: begin
                        alu_b = csr_rdata;
                        alu_op = rv_exec_pkg::alu_or;
                        csr_wen = 1'b1;
                        csr_ctl = rv_exec_pkg::csr_write;
                    end
                    default: rd_wen = 1'b0;
                endcase
            end
            default: rd_wen = 1'b0;
        endcase
    end

    always_comb begin
        mem_req.address = alu_result;
        mem_req.wdata = src2 << {byte_off, 3'b000};
        mem_req.read = (opcode == rv_isa_pkg::op_load);
        mem_req.write = (opcode == rv_isa_pkg::op_store);
        case (funct3)
            rv_isa_pkg::f3_byte: mem_req.wmask = 4'b0001 << byte_off;
            rv_isa_pkg::f3_half: mem_req.wmask = 4'b0011 << byte_off;
            default:             mem_req.wmask = 4'b1111;
        endcase
    end

    assign load_shifted = mem_rdata >> {byte_off, 3'b000};

    always_comb begin
        case (funct3)
            rv_isa_pkg::f3_byte:   load_word = {{24{load_shifted[7]}}, load_shifted[7:0]};
            rv_isa_pkg::f3_half:   load_word = {{16{load_shifted[15]}}, load_shifted[15:0]};
            rv_isa_pkg::f3_word:   load_word = load_shifted;
            rv_isa_pkg::f3_byte_u: load_word = {24'b0, load_shifted[7:0]};
            rv_isa_pkg::f3_half_u: load_word = {16'b0, load_shifted[15:0]};
            default:               load_word = load_shifted;
        endcase
    end

    rv_alu u_alu (
        .a        (alu_a),
        .b        (alu_b),
        .op       (alu_op),
        .sub      (alu_sub),
        .sign     (alu_sign),
        .result   (alu_result),
        .zero     (alu_zero),
        .overflow (),
        .carry    ()
    );

    rv_data_mem u_dmem (
        .clk    (clk),
        .req    (mem_req),
        .accept (accept),
        .rdata  (mem_rdata)
    );

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_core (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  rv_isa_pkg::word_t    instr,
    output rv_isa_pkg::word_t    pc,
    output rv_exec_pkg::retire_t retire
);

    rv_isa_pkg::word_t regs [32];
    rv_isa_pkg::opcode_e opcode;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    rv_isa_pkg::word_t imm;
    rv_isa_pkg::word_t src1;
    rv_isa_pkg::word_t src2;
    rv_isa_pkg::word_t result;
    rv_isa_pkg::word_t next_pc;
    rv_isa_pkg::word_t csr_rdata;
    rv_isa_pkg::word_t csr_wdata;
    rv_isa_pkg::word_t trap_target;
    rv_exec_pkg::csr_ctl_e csr_ctl;
    logic rd_wen;
    logic rd_write;
    logic csr_wen;

    assign opcode = rv_isa_pkg::opcode_e'(instr[6:0]);
    assign rd = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign src1 = regs[rs1]; // x0 is never written
    assign src2 = regs[rs2];
    assign rd_write = rd_wen && (rd != '0);

    always_comb begin
        case (opcode)
            rv_isa_pkg::op_store:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_isa_pkg::op_branch:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc:
                imm = {instr[31:12], 12'b0};
            rv_isa_pkg::op_jal:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default: // I form, also carries bit 30 and the system field
                imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else if (instr_valid) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (instr_valid && rd_write) begin
            regs[rd] <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= instr_valid;
            if (instr_valid) begin
                retire.pc <= pc;
                retire.rd <= rd;
                retire.rd_wen <= rd_write;
                retire.rd_data <= result;
            end
        end
    end

    rv_exu u_exu (
        .clk         (clk),
        .accept      (instr_valid),
        .opcode      (opcode),
        .funct3      (instr[14:12]),
        .src1        (src1),
        .src2        (src2),
        .imm         (imm),
        .pc          (pc),
        .csr_rdata   (csr_rdata),
        .trap_target (trap_target),
        .result      (result),
        .rd_wen      (rd_wen),
        .next_pc     (next_pc),
        .csr_wdata   (csr_wdata),
        .csr_wen     (csr_wen),
        .csr_ctl     (csr_ctl)
    );

    rv_csr_file u_csr (
        .clk         (clk),
        .reset       (reset),
        .accept      (instr_valid),
        .addr        (instr[31:20]),
        .wdata       (csr_wdata),
        .wen         (csr_wen),
        .ctl         (csr_ctl),
        .pc          (pc),
        .rdata       (csr_rdata),
        .trap_target (trap_target)
    );

endmodule

// ==== testbench/rv_core_properties.sv ====
`timescale 1ns/1ns

module rv_core_properties (
    input logic                 clk,
    input logic                 reset,
    input logic                 instr_valid,
    input rv_isa_pkg::word_t    instr,
    input rv_isa_pkg::word_t    pc,
    input rv_exec_pkg::retire_t retire
);

    logic plain_op;
    int fail_count = 0; // read by the testbench at the end

    // everything that falls through to pc+4
    assign plain_op = instr[6:0] inside {rv_isa_pkg::op_imm, rv_isa_pkg::op_reg,
                                         rv_isa_pkg::op_load, rv_isa_pkg::op_store,
                                         rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc};

    retire_idle_after_reset: assert property (@(posedge clk) reset |=> !retire.valid)
        else begin
            $error("retire.valid high right after reset");
            fail_count++;
        end

    no_x0_write: assert property (@(posedge clk) disable iff (reset)
        retire.rd_wen |-> retire.rd != '0)
        else begin
            $error("retire reports a write to x0");
            fail_count++;
        end

    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else begin
            $error("pc not word aligned");
            fail_count++;
        end

    pc_step: assert property (@(posedge clk) disable iff (reset)
        instr_valid && plain_op |=> pc == $past(pc) + 32'd4)
        else begin
            $error("pc did not advance by 4");
            fail_count++;
        end

endmodule

bind rv_core rv_core_properties u_props (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .retire      (retire)
);

// ==== testbench/rv_core_tb.sv ====
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_core_tb;

    localparam int retire_timeout = 8;

    logic clk;
    logic reset;
    logic instr_valid;
    rv_isa_pkg::word_t instr;
    rv_isa_pkg::word_t pc;
    rv_exec_pkg::retire_t retire;

    rv_isa_pkg::word_t ref_regs [32]; // reference register file
    logic [7:0] ref_mem [1024]; // reference data memory, byte wide
    rv_isa_pkg::word_t ref_pc;
    int errors;
    int checks;

    rv_core DUT (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .retire      (retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic rv_isa_pkg::word_t i_type(input logic [11:0] imm,
            input rv_isa_pkg::reg_idx_t rs1, input rv_isa_pkg::funct3_t f3,
            input rv_isa_pkg::reg_idx_t rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_isa_pkg::word_t r_type(input logic [6:0] f7,
            input rv_isa_pkg::reg_idx_t rs2, input rv_isa_pkg::reg_idx_t rs1,
            input rv_isa_pkg::funct3_t f3, input rv_isa_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::op_reg};
    endfunction

    function automatic rv_isa_pkg::word_t s_type(input logic [11:0] imm,
            input rv_isa_pkg::reg_idx_t rs2, input rv_isa_pkg::reg_idx_t rs1,
            input rv_isa_pkg::funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::op_store};
    endfunction

    function automatic rv_isa_pkg::word_t b_type(input logic [12:0] imm,
            input rv_isa_pkg::reg_idx_t rs2, input rv_isa_pkg::reg_idx_t rs1,
            input rv_isa_pkg::funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::op_branch};
    endfunction

    function automatic rv_isa_pkg::word_t u_type(input logic [19:0] imm,
            input rv_isa_pkg::reg_idx_t rd, input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic rv_isa_pkg::word_t j_type(input logic [20:0] imm,
            input rv_isa_pkg::reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::op_jal};
    endfunction

    function automatic rv_isa_pkg::word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // expected ALU value from the RV32I rules
    function automatic rv_isa_pkg::word_t alu_ref(input int f3, input int alt,
            input rv_isa_pkg::word_t a, input rv_isa_pkg::word_t b);
        rv_isa_pkg::word_t r;
        case (f3)
            0: r = alt ? a - b : a + b;
            1: r = a << b[4:0];
            2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3: r = (a < b) ? 32'd1 : 32'd0;
            4: r = a ^ b;
            5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_ref(input int f3, input rv_isa_pkg::word_t a,
            input rv_isa_pkg::word_t b);
        case (f3)
            0: return a == b;
            1: return a != b;
            4: return $signed(a) < $signed(b);
            5: return $signed(a) >= $signed(b);
            6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check_word(input string what, input rv_isa_pkg::word_t got,
            input rv_isa_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s of instr %h got %h expected %h",
                     $time, what, instr, got, exp);
        end
    endtask

    // one accepted instruction, then compare retire and the next pc
    task automatic issue(input rv_isa_pkg::word_t ins, input logic wen,
            input rv_isa_pkg::word_t data, input rv_isa_pkg::word_t npc);
        int waited;
        rv_isa_pkg::reg_idx_t rd;
        rd = ins[11:7];
        instr = ins;
        instr_valid = 1'b1;
        @(posedge clk);
        #5;
        instr_valid = 1'b0;
        waited = 0;
        while (retire.valid !== 1'b1 && waited < retire_timeout) begin
            @(posedge clk);
            #5;
            waited++;
        end
        if (retire.valid !== 1'b1) begin
            $display("retire.valid stayed low for %0d cycles after instr %h", waited, ins);
            $display("Test failed");
            $finish;
        end else begin
            check_word("retire.pc", retire.pc, ref_pc);
            check_word("retire.rd_wen", retire.rd_wen, wen && rd != 0);
            if (wen) begin
                check_word("retire.rd", retire.rd, rd);
            end
            if (wen && rd != 0) begin
                check_word("retire.rd_data", retire.rd_data, data);
                ref_regs[rd] = data;
            end
            check_word("pc", pc, npc);
            ref_pc = npc;
        end
    endtask

    task automatic exec_rd(input rv_isa_pkg::word_t ins, input rv_isa_pkg::word_t data);
        issue(ins, 1'b1, data, ref_pc + 4);
    endtask

    task automatic set_reg(input rv_isa_pkg::reg_idx_t rd, input rv_isa_pkg::word_t value);
        logic [19:0] hi;
        hi = value[31:12] + value[11]; // addi sign-extends the low part
        exec_rd(u_type(hi, rd, rv_isa_pkg::op_lui), {hi, 12'b0});
        exec_rd(i_type(value[11:0], rd, 3'd0, rd, rv_isa_pkg::op_imm), value);
    endtask

    task automatic store(input rv_isa_pkg::funct3_t f3, input rv_isa_pkg::reg_idx_t rs2,
            input int off);
        rv_isa_pkg::word_t addr;
        rv_isa_pkg::word_t data;
        addr = ref_regs[5] + off;
        data = ref_regs[rs2];
        issue(s_type(off[11:0], rs2, 5'd5, f3), 1'b0, '0, ref_pc + 4);
        for (int k = 0; k < (1 << f3); k++) begin
            ref_mem[10'(addr + k)] = data[8*k +: 8];
        end
    endtask

    task automatic load(input rv_isa_pkg::funct3_t f3, input int off);
        rv_isa_pkg::word_t addr;
        rv_isa_pkg::word_t raw;
        rv_isa_pkg::word_t exp;
        addr = ref_regs[5] + off;
        raw = {ref_mem[10'(addr + 3)], ref_mem[10'(addr + 2)],
               ref_mem[10'(addr + 1)], ref_mem[10'(addr)]};
        case (f3)
            3'd0: exp = {{24{raw[7]}}, raw[7:0]};
            3'd1: exp = {{16{raw[15]}}, raw[15:0]};
            3'd4: exp = {24'b0, raw[7:0]};
            3'd5: exp = {16'b0, raw[15:0]};
            default: exp = raw;
        endcase
        exec_rd(i_type(off[11:0], 5'd5, f3, 5'd8, rv_isa_pkg::op_load), exp);
    endtask

    task automatic alu_tests();
        rv_isa_pkg::word_t a;
        rv_isa_pkg::word_t b;
        logic [11:0] imm;
        set_reg(1, $urandom | 32'h8000_0000); // negative operand
        set_reg(2, $urandom & 32'h7fff_ffff);
        for (int s = 1; s <= 2; s++) begin
            a = ref_regs[s];
            b = ref_regs[3 - s];
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    if (alt == 0 || f3 == 0 || f3 == 5) begin
                        imm = $urandom;
                        if (f3 == 1 || f3 == 5) begin
                            imm = {1'b0, alt[0], 5'b0, imm[4:0]}; // shamt form
                        end
                        if (!(f3 == 0 && alt == 1)) begin
                            exec_rd(i_type(imm, s, f3, 5'd4, rv_isa_pkg::op_imm),
                                    alu_ref(f3, alt, a, sext12(imm)));
                        end
                        exec_rd(r_type({1'b0, alt[0], 5'b0}, 3 - s, s, f3, 5'd5),
                                alu_ref(f3, alt, a, b));
                    end
                end
            end
        end
    endtask

    task automatic mem_tests();
        set_reg(5, 32'h108); // base, offsets reach -8..7
        set_reg(6, $urandom);
        set_reg(7, $urandom | 32'h8080_8080); // sign bits set in every lane
        store(rv_isa_pkg::f3_word, 6, -8);
        store(rv_isa_pkg::f3_word, 7, -4);
        store(rv_isa_pkg::f3_word, 6, 0);
        store(rv_isa_pkg::f3_word, 7, 4);
        store(rv_isa_pkg::f3_byte, 7, -3);
        store(rv_isa_pkg::f3_half, 6, 2);
        store(rv_isa_pkg::f3_byte, 6, 7);
        store(rv_isa_pkg::f3_half, 7, -6);
        for (int off = -8; off < 8; off++) begin
            load(rv_isa_pkg::f3_byte, off);
            load(rv_isa_pkg::f3_byte_u, off);
            if ((off & 1) == 0) begin
                load(rv_isa_pkg::f3_half, off);
                load(rv_isa_pkg::f3_half_u, off);
            end
            if ((off & 3) == 0) begin
                load(rv_isa_pkg::f3_word, off);
            end
        end
    endtask

    task automatic x0_idle_tests();
        rv_isa_pkg::word_t hold_pc;
        issue(i_type(12'h005, 5'd1, 3'd0, 5'd0, rv_isa_pkg::op_imm), 1'b1, '0, ref_pc + 4);
        issue(u_type(20'habcde, 5'd0, rv_isa_pkg::op_lui), 1'b1, '0, ref_pc + 4);
        exec_rd(r_type(7'd0, 5'd0, 5'd0, 3'd0, 5'd14), 32'd0); // x0 still reads zero
        hold_pc = ref_pc;
        instr_valid = 1'b0;
        for (int c = 0; c < 4; c++) begin
            if (c < 2) begin
                instr = s_type(12'h0, 5'd1, 5'd5, rv_isa_pkg::f3_word); // store left on the bus
            end else begin
                instr = i_type(12'h001, 5'd2, 3'd0, 5'd2, rv_isa_pkg::op_imm); // addi x2
            end
            @(posedge clk);
            #5;
            check_word("pc while idle", pc, hold_pc);
            check_word("retire.valid while idle", retire.valid, 32'd0);
        end
        load(rv_isa_pkg::f3_word, 0);
        exec_rd(r_type(7'd0, 5'd0, 5'd2, 3'd0, 5'd15), ref_regs[2]);
    endtask

    task automatic branch_tests();
        int br_f3 [6] = '{0, 1, 4, 5, 6, 7};
        int off;
        int rs1;
        int rs2;
        logic taken;
        set_reg(1, $urandom | 32'h8000_0000);
        set_reg(2, $urandom & 32'h7fff_ffff);
        foreach (br_f3[i]) begin
            for (int p = 0; p < 3; p++) begin
                rs1 = (p == 1) ? 2 : 1;
                rs2 = (p == 0) ? 2 : 1; // third pair compares equal values
                off = int'($urandom % 64);
                off = (off - 32) * 4;
                taken = branch_ref(br_f3[i], ref_regs[rs1], ref_regs[rs2]);
                issue(b_type(off[12:0], rs2, rs1, br_f3[i]), 1'b0, '0,
                      taken ? ref_pc + off : ref_pc + 4);
            end
        end
    endtask

    task automatic jump_tests();
        int off;
        rv_isa_pkg::word_t base;
        off = int'($urandom % 512);
        off = (off - 256) * 4;
        issue(j_type(off[20:0], 5'd9), 1'b1, ref_pc + 4, ref_pc + off);
        base = ($urandom & 32'h0000_fffc) | 32'd1; // bit 0 must be dropped
        set_reg(10, base);
        off = int'($urandom % 256);
        off = (off - 128) * 4;
        issue(i_type(off[11:0], 5'd10, 3'd0, 5'd11, rv_isa_pkg::op_jalr), 1'b1,
              ref_pc + 4, (base + off) & ~32'd1);
    endtask

    task automatic upper_imm_tests();
        logic [19:0] imm;
        imm = $urandom;
        exec_rd(u_type(imm, 5'd12, rv_isa_pkg::op_lui), {imm, 12'b0});
        exec_rd(u_type(imm, 5'd13, rv_isa_pkg::op_auipc), ref_pc + {imm, 12'b0});
    endtask

    task automatic trap_tests();
        rv_isa_pkg::word_t handler;
        rv_isa_pkg::word_t trap_pc;
        handler = $urandom & 32'h0000_ff00;
        set_reg(1, handler);
        set_reg(2, 32'h40);
        exec_rd(i_type(rv_isa_pkg::csr_mtvec, 5'd1, rv_isa_pkg::f3_csrrw, 5'd16,
                       rv_isa_pkg::op_system), 32'd0);
        exec_rd(i_type(rv_isa_pkg::csr_mtvec, 5'd2, rv_isa_pkg::f3_csrrs, 5'd17,
                       rv_isa_pkg::op_system), handler);
        handler = handler | 32'h40;
        exec_rd(i_type(rv_isa_pkg::csr_mtvec, 5'd0, rv_isa_pkg::f3_csrrs, 5'd18,
                       rv_isa_pkg::op_system), handler);
        trap_pc = ref_pc;
        issue(32'h0000_0073, 1'b0, '0, handler); // ecall
        exec_rd(i_type(rv_isa_pkg::csr_mepc, 5'd0, rv_isa_pkg::f3_csrrs, 5'd19,
                       rv_isa_pkg::op_system), trap_pc);
        exec_rd(i_type(rv_isa_pkg::csr_mcause, 5'd0, rv_isa_pkg::f3_csrrs, 5'd20,
                       rv_isa_pkg::op_system), 32'd11);
        issue(32'h3020_0073, 1'b0, '0, trap_pc); // mret
        trap_pc = ref_pc;
        issue(32'h0010_0073, 1'b0, '0, handler); // ebreak
        exec_rd(i_type(rv_isa_pkg::csr_mcause, 5'd0, rv_isa_pkg::f3_csrrs, 5'd21,
                       rv_isa_pkg::op_system), 32'd3);
        issue(32'h3020_0073, 1'b0, '0, trap_pc);
    endtask

    initial begin
        void'($urandom(29));
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        errors = 0;
        checks = 0;
        ref_pc = `RV_RESET_PC;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;
        check_word("pc after reset", pc, `RV_RESET_PC);
        check_word("retire.valid after reset", retire.valid, 32'd0);
        alu_tests();
        mem_tests();
        x0_idle_tests();
        branch_tests();
        jump_tests();
        upper_imm_tests();
        trap_tests();
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, DUT.u_props.fail_count);
        if (errors == 0 && DUT.u_props.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+src
src/rv_isa_pkg.sv
src/rv_exec_pkg.sv
src/rv_alu.sv
src/rv_data_mem.sv
src/rv_csr_file.sv
src/rv_exu.sv
src/rv_core.sv
testbench/rv_core_properties.sv
testbench/rv_core_tb.sv
